//--- icache.f
icache_pkg.sv
icache_fetch_port.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
icache_mem_model.sv
icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the icache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line missing from simulation output"
exit 1

//--- icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    import icache_pkg::*;

    localparam int          num_sets      = 8;
    localparam int          num_ways      = 4;
    localparam int          block_words   = 4;
    localparam int          seed          = 99646;
    localparam int          num_fetches   = 400;
    localparam logic [31:0] xor_key       = 32'h5a3c_96e1;
    localparam logic [31:0] addr_base     = 32'h0001_0000;
    // Six tags per set against four ways
    localparam int          tags_per_set  = 6;
    localparam int          line_bytes    = block_words * 4;
    localparam int          set_stride    = num_sets * line_bytes;
    localparam int          addr_words    = set_stride * tags_per_set / 4;
    // Random fetches plus the conflict and flush sequences
    localparam int          total_fetches = num_fetches + 2 * tags_per_set + 3 * num_sets;
    // About 23 cycles per fetch at worst, plus margin
    localparam int          cycle_limit   = total_fetches * 25;

    logic       Clk;
    logic       arst_n;
    logic       req_valid;
    fetch_req_t req;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       busy;
    logic       flush;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_beat_valid;
    mem_beat_t  mem_beat;

    // Reference cache state
    logic [num_ways-1:0] model_valid [num_sets];
    logic [31:0]         model_tag   [num_sets][num_ways];
    int                  model_rr    [num_sets];

    logic [31:0] conflict_addr [tags_per_set];
    logic [31:0] spread_addr   [num_sets];
    int          cycle_count;

    icache_top #(
        .num_sets    (num_sets),
        .num_ways    (num_ways),
        .block_words (block_words)
    ) icache_top_i (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .busy           (busy),
        .flush          (flush),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    icache_mem_model #(
        .block_words (block_words),
        .xor_key     (xor_key)
    ) mem_model_i (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge Clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("tests failed");
        $fatal(1, "Cycle limit reached");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic int set_of(input logic [31:0] addr);
        return (addr / line_bytes) % num_sets;
    endfunction

    function automatic logic [31:0] tag_of(input logic [31:0] addr);
        return addr / set_stride;
    endfunction

    task automatic model_clear(input bit with_pointers);
        for (int s = 0; s < num_sets; s++) begin
            model_valid[s] = '0;
            if (with_pointers) begin
                model_rr[s] = 0;
            end
        end
    endtask

    function automatic logic model_hit(input logic [31:0] addr);
        int s;
        s = set_of(addr);
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == tag_of(addr)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // First invalid way, else the set's round-robin victim
    task automatic model_fill(input logic [31:0] addr);
        int s;
        int way;
        s   = set_of(addr);
        way = -1;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!model_valid[s][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way         = model_rr[s];
            model_rr[s] = (model_rr[s] + 1) % num_ways;
        end
        model_valid[s][way] = 1'b1;
        model_tag[s][way]   = tag_of(addr);
    endtask

    // Called on a falling edge with busy low
    task automatic do_fetch(input logic [31:0] addr);
        logic exp_hit;
        int   req_count;
        int   cycles;
        exp_hit = model_hit(addr);
        if (!exp_hit) begin
            model_fill(addr);
        end
        req_count = 0;
        req_valid = 1'b1;
        req.addr  = addr;
        @(negedge Clk);
        req_valid = 1'b0;
        cycles    = 1;
        while (!rsp_valid) begin
            // Busy from acceptance until the response
            check_value("busy", 32'(busy), 32'd1);
            if (mem_req_valid) begin
                req_count++;
                check_value("mem_req.addr", mem_req.addr, (addr / line_bytes) * line_bytes);
            end
            @(negedge Clk);
            cycles++;
        end
        check_value("mem_req_valid strobes", req_count, exp_hit ? 0 : 1);
        check_value("rsp.instr", rsp.instr, addr ^ xor_key);
        if (exp_hit) begin
            check_value("hit latency", cycles, 2);
        end
        // Busy drops at the edge after the response
        @(negedge Clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(negedge Clk);
        flush = 1'b0;
        model_clear(1'b0);
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(seed));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        model_clear(1'b1);
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        arst_n = 1'b1;
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);

        // Conflicts in set 3, then refetch to see the eviction order
        for (int t = 0; t < tags_per_set; t++) begin
            conflict_addr[t] = addr_base + 32'(t * set_stride + 3 * line_bytes)
                             + 32'(4 * (t % block_words));
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < tags_per_set; t++) begin
                do_fetch(conflict_addr[t]);
            end
        end

        for (int n = 0; n < num_fetches; n++) begin
            if ($urandom_range(19, 0) == 0) begin
                do_flush();
            end
            addr = addr_base + 4 * $urandom_range(addr_words - 1, 0);
            do_fetch(addr);
            repeat ($urandom_range(1, 0)) @(negedge Clk);
        end

        // One line per set, flushed, then fetched twice more
        for (int s = 0; s < num_sets; s++) begin
            spread_addr[s] = addr_base + 32'(s * line_bytes + 4 * (s % block_words));
            do_fetch(spread_addr[s]);
        end
        do_flush();
        for (int pass = 0; pass < 2; pass++) begin
            for (int s = 0; s < num_sets; s++) begin
                do_fetch(spread_addr[s]);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter int          block_words = 4,
    parameter logic [31:0] xor_key     = 32'h0
) (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic                  mem_req_valid,
    input  icache_pkg::mem_req_t  mem_req,
    output logic                  mem_beat_valid,
    output icache_pkg::mem_beat_t mem_beat
);

    import icache_pkg::*;

    logic [addr_width-1:0] base;
    int unsigned           gap;

    // Each block read answered in ascending word order, 0 to 3 idle cycles per beat
    initial begin
        mem_beat_valid = 1'b0;
        mem_beat       = '0;
        forever begin
            @(negedge Clk);
            if (arst_n && mem_req_valid) begin
                base = mem_req.addr;
                for (int i = 0; i < block_words; i++) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap) @(negedge Clk);
                    mem_beat_valid = 1'b1;
                    mem_beat.data  = (base + 32'(4 * i)) ^ xor_key;
                    @(negedge Clk);
                    mem_beat_valid = 1'b0;
                end
            end
        end
    end

endmodule

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int num_sets    = 8,
    parameter int num_ways    = 4,
    parameter int block_words = 4
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    output logic                   busy,
    input  logic                   flush,
    output logic                   mem_req_valid,
    output icache_pkg::mem_req_t   mem_req,
    input  logic                   mem_beat_valid,
    input  icache_pkg::mem_beat_t  mem_beat
);

    import icache_pkg::*;

    logic                    lookup_valid;
    fetch_req_t              lookup_req;
    logic                    done;
    logic                    miss_valid;
    fetch_req_t              miss_req;
    logic                    fill_valid;
    word_t [block_words-1:0] fill_line;

    icache_fetch_port fetch_port_i (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .done         (done),
        .busy         (busy),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req)
    );

    icache_lookup #(
        .num_sets    (num_sets),
        .num_ways    (num_ways),
        .block_words (block_words)
    ) lookup_i (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req),
        .fill_valid   (fill_valid),
        .fill_line    (fill_line),
        .miss_valid   (miss_valid),
        .miss_req     (miss_req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .done         (done)
    );

    icache_refill #(
        .block_words (block_words)
    ) refill_i (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .miss_valid     (miss_valid),
        .miss_req       (miss_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .fill_valid     (fill_valid),
        .fill_line      (fill_line)
    );

endmodule

//--- icache_refill.sv
`timescale 1ns/1ps

module icache_refill #(
    parameter int block_words = 4
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                miss_valid,
    input  icache_pkg::fetch_req_t              miss_req,
    input  logic                                mem_beat_valid,
    input  icache_pkg::mem_beat_t               mem_beat,
    output logic                                mem_req_valid,
    output icache_pkg::mem_req_t                mem_req,
    output logic                                fill_valid,
    output icache_pkg::word_t [block_words-1:0] fill_line
);

    import icache_pkg::*;

    localparam int offset_w = $clog2(block_words);
    localparam int block_lo = 2 + offset_w;

    // Request sent, line not yet complete
    logic                req_open;
    logic [offset_w-1:0] beat_cnt;
    logic                take_beat;
    logic                last_beat;

    assign take_beat = mem_beat_valid && req_open;
    assign last_beat = (beat_cnt == offset_w'(block_words - 1));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_req_valid <= 1'b0;
            fill_valid    <= 1'b0;
            req_open      <= 1'b0;
            beat_cnt      <= '0;
        end else begin
            mem_req_valid <= 1'b0;
            fill_valid    <= 1'b0;
            if (miss_valid) begin
                mem_req_valid <= 1'b1;
                req_open      <= 1'b1;
                beat_cnt      <= '0;
            end
            if (take_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    // Whole line gathered, hand it to lookup
                    req_open   <= 1'b0;
                    fill_valid <= 1'b1;
                end
            end
        end
    end

    // Block address and line buffer
    always_ff @(posedge Clk) begin
        if (miss_valid) begin
            mem_req.addr <= {miss_req.addr[addr_width-1:block_lo], {block_lo{1'b0}}};
        end
        if (take_beat) begin
            fill_line[beat_cnt] <= mem_beat.data;
        end
    end

    // Memory speaks only in answer to a block request
    a_beat_needs_req: assert property (
        @(posedge Clk) disable iff (!arst_n)
        mem_beat_valid |-> req_open
    );

    // One miss at a time
    a_no_overlap: assert property (
        @(posedge Clk) disable iff (!arst_n)
        miss_valid |-> !req_open
    );

endmodule

//--- icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
    parameter int num_sets    = 8,
    parameter int num_ways    = 4,
    parameter int block_words = 4
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                flush,
    input  logic                                lookup_valid,
    input  icache_pkg::fetch_req_t              lookup_req,
    input  logic                                fill_valid,
    input  icache_pkg::word_t [block_words-1:0] fill_line,
    output logic                                miss_valid,
    output icache_pkg::fetch_req_t              miss_req,
    output logic                                rsp_valid,
    output icache_pkg::fetch_rsp_t              rsp,
    output logic                                done
);

    import icache_pkg::*;

    localparam int offset_w = $clog2(block_words);
    localparam int index_w  = $clog2(num_sets);
    localparam int way_w    = $clog2(num_ways);
    localparam int index_lo = 2 + offset_w;
    localparam int tag_lo   = index_lo + index_w;
    localparam int tag_w    = addr_width - tag_lo;

    logic [num_ways-1:0]     valid_arr [num_sets];
    logic [way_w-1:0]        rr_ptr    [num_sets];
    logic [tag_w-1:0]        tag_arr   [num_sets][num_ways];
    word_t [block_words-1:0] data_arr  [num_sets][num_ways];

    logic                miss_pending;
    logic [offset_w-1:0] req_offset;
    logic [index_w-1:0]  req_index;
    logic [tag_w-1:0]    req_tag;
    logic [offset_w-1:0] miss_offset;
    logic [index_w-1:0]  miss_index;
    logic [tag_w-1:0]    miss_tag;
    logic [num_ways-1:0] hit_vec;
    logic                hit;
    logic [way_w-1:0]    hit_way;
    logic [way_w-1:0]    fill_way;
    logic                set_full;
    logic [way_w-1:0]    rr_next;

    assign req_offset  = lookup_req.addr[index_lo-1:2];
    assign req_index   = lookup_req.addr[tag_lo-1:index_lo];
    assign req_tag     = lookup_req.addr[addr_width-1:tag_lo];
    assign miss_offset = miss_req.addr[index_lo-1:2];
    assign miss_index  = miss_req.addr[tag_lo-1:index_lo];
    assign miss_tag    = miss_req.addr[addr_width-1:tag_lo];

    // Compare every way of the indexed set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_arr[req_index][w] && (tag_arr[req_index][w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // Lowest invalid way, else the round-robin victim
    always_comb begin
        fill_way = rr_ptr[miss_index];
        set_full = 1'b1;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_arr[miss_index][w]) begin
                fill_way = way_w'(w);
                set_full = 1'b0;
            end
        end
    end

    assign rr_next = (rr_ptr[miss_index] == way_w'(num_ways - 1)) ? '0 :
                     rr_ptr[miss_index] + 1'b1;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_valid   <= 1'b0;
            rsp_valid    <= 1'b0;
            miss_pending <= 1'b0;
            for (int s = 0; s < num_sets; s++) begin
                valid_arr[s] <= '0;
                rr_ptr[s]    <= '0;
            end
        end else begin
            miss_valid <= 1'b0;
            rsp_valid  <= 1'b0;
            if (flush) begin
                for (int s = 0; s < num_sets; s++) begin
                    valid_arr[s] <= '0;
                end
            end
            if (lookup_valid) begin
                if (hit) begin
                    rsp_valid <= 1'b1;
                end else begin
                    miss_valid   <= 1'b1;
                    miss_pending <= 1'b1;
                end
            end
            if (fill_valid) begin
                valid_arr[miss_index][fill_way] <= 1'b1;
                if (set_full) begin
                    rr_ptr[miss_index] <= rr_next;
                end
                miss_pending <= 1'b0;
                rsp_valid    <= 1'b1;
            end
        end
    end

    // Tag and data storage, response word
    always_ff @(posedge Clk) begin
        if (lookup_valid) begin
            miss_req <= lookup_req;
            if (hit) begin
                rsp.instr <= data_arr[req_index][hit_way][req_offset];
            end
        end
        if (fill_valid) begin
            tag_arr[miss_index][fill_way]  <= miss_tag;
            data_arr[miss_index][fill_way] <= fill_line;
            rsp.instr                      <= fill_line[miss_offset];
        end
    end

    assign done = rsp_valid;

    // A block is never held in two ways of a set
    a_single_hit: assert property (
        @(posedge Clk) disable iff (!arst_n)
        lookup_valid |-> $onehot0(hit_vec)
    );

    // Refill returns a line only for the miss kept here
    a_fill_for_miss: assert property (
        @(posedge Clk) disable iff (!arst_n)
        fill_valid |-> miss_pending
    );

endmodule

//--- icache_fetch_port.sv
`timescale 1ns/1ps

module icache_fetch_port (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    input  logic                   done,
    output logic                   busy,
    output logic                   lookup_valid,
    output icache_pkg::fetch_req_t lookup_req
);

    logic accept;

    assign accept = req_valid && !busy;

    // Busy from acceptance until the edge after the response
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Address held for lookup and for the whole miss
    always_ff @(posedge Clk) begin
        if (accept) begin
            lookup_req <= req;
        end
    end

    // The core waits for the previous fetch to finish
    a_no_req_while_busy: assert property (
        @(posedge Clk) disable iff (!arst_n)
        req_valid |-> !busy
    );

endmodule

//--- icache_pkg.sv
package icache_pkg;

    // Byte address width on both sides of the cache
    localparam int addr_width = 32;

    // Instruction and memory word width
    localparam int word_width = 32;

    typedef logic [word_width-1:0] word_t;

    // Fetch from the core, byte address of one instruction
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } fetch_req_t;

    // Answer to the core
    typedef struct packed {
        word_t instr;
    } fetch_rsp_t;

    // Block read toward the memory controller, always block aligned
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } mem_req_t;

    // One data beat of a block read
    typedef struct packed {
        word_t data;
    } mem_beat_t;

endpackage
